// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module mult_top_tb -f booth_mult.f
	@out="$$(./obj_dir/Vmult_top_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== booth_mult.f ====
design/booth_pkg.sv
design/bus_pkg.sv
design/operand_encoder.sv
design/sync_fifo.sv
design/booth_accumulator.sv
design/result_master.sv
design/mult_top.sv
tb/mult_top_sva.sv
tb/mult_top_tb.sv

// ==== design/booth_accumulator.sv ====
`timescale 1ns/100ps

module booth_accumulator (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  booth_pkg::digit_t   digit_data,
  input  logic                digit_empty,
  input  logic                res_full,
  output logic                digit_pop,
  output logic                res_push,
  output booth_pkg::product_t res_data
);

  typedef logic signed [booth_pkg::OP_W+booth_pkg::RADIX_BITS-1:0] mult_t;

  logic signed [booth_pkg::ACC_W-1:0] acc;
  logic signed [booth_pkg::ACC_W-1:0] base;
  logic signed [booth_pkg::ACC_W-1:0] sum;
  logic signed [booth_pkg::ACC_W-1:0] next_acc;
  logic                               mid_op;  // inside an operation
  logic                               neg;
  logic [booth_pkg::RADIX_BITS:0]     abs_digit;
  logic [booth_pkg::RADIX_BITS-1:0]   mag;     // 0 .. 8
  mult_t                              mcand_ext;
  mult_t                              mag_mult;
  mult_t                              multiple;

  // the last digit waits for room in the result FIFO
  assign digit_pop = !digit_empty && !(digit_data.last && res_full);
  assign res_push  = digit_pop && digit_data.last;

  assign neg       = digit_data.digit[booth_pkg::RADIX_BITS];
  assign abs_digit = neg ? -digit_data.digit : digit_data.digit;
  assign mag       = abs_digit[booth_pkg::RADIX_BITS-1:0];
  assign mcand_ext = {{booth_pkg::RADIX_BITS{digit_data.mcand[booth_pkg::OP_W-1]}},
                      digit_data.mcand};

  // multiple of the multiplicand from shifted copies
  always_comb begin
    mag_mult = '0;
    for (int i = 0; i < booth_pkg::RADIX_BITS; i++) begin
      if (mag[i]) begin
        mag_mult = mag_mult + (mcand_ext <<< i);
      end
    end
    multiple = neg ? -mag_mult : mag_mult;
  end

  assign base     = mid_op ? acc : '0;  // first digit starts clean
  assign sum      = base + {multiple, {booth_pkg::OP_W{1'b0}}};  // add at bit 16
  assign next_acc = sum >>> booth_pkg::RADIX_BITS;
  assign res_data = next_acc[booth_pkg::PROD_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_op <= 1'b0;
    end else if (clear) begin
      mid_op <= 1'b0;
    end else if (digit_pop) begin
      mid_op <= !digit_data.last;
    end
  end

  always_ff @(posedge clk) begin
    if (digit_pop) begin
      acc <= next_acc;
    end
  end

endmodule

// ==== design/booth_pkg.sv ====
package booth_pkg;

  localparam int OP_W       = 16;  // multiplier and multiplicand width
  localparam int RADIX_BITS = 4;   // multiplier bits retired per digit
  localparam int NUM_DIGITS = 4;   // digits per operation, OP_W / RADIX_BITS
  localparam int ACC_W      = 36;  // room for the +-8 multiple of -32768
  localparam int PROD_W     = 32;  // full signed product

  // one recoded digit travelling from encoder to accumulator
  typedef struct packed {
    logic signed [RADIX_BITS:0] digit;  // -8 .. +8
    logic [OP_W-1:0]            mcand;  // multiplicand, two's complement
    logic                       last;   // closes the operation
  } digit_t;

  typedef logic signed [PROD_W-1:0] product_t;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

  // operand word: multiplier in [31:16], multiplicand in [15:0]
  localparam int DAT_W = 32;

  localparam int DIGIT_FIFO_DEPTH  = 8;  // two operations of digits
  localparam int RESULT_FIFO_DEPTH = 4;  // products waiting for the bus

endpackage

// ==== design/mult_top.sv ====
`timescale 1ns/100ps

module mult_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clear,
  input  logic                      op_cyc,
  input  logic                      op_stb,
  input  logic [bus_pkg::DAT_W-1:0] op_dat,
  output logic                      op_ack,
  output logic                      res_cyc,
  output logic                      res_stb,
  output booth_pkg::product_t       res_dat,
  input  logic                      res_ack
);

  booth_pkg::digit_t   enc_digit;   // encoder to digit FIFO
  booth_pkg::digit_t   head_digit;  // digit FIFO to accumulator
  logic                digit_push;
  logic                digit_pop;
  logic                digit_full;
  logic                digit_empty;
  booth_pkg::product_t acc_product;
  booth_pkg::product_t head_product;
  logic                res_push;
  logic                res_pop;
  logic                res_full;
  logic                res_empty;

  operand_encoder i_operand_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear      (clear),
    .op_cyc     (op_cyc),
    .op_stb     (op_stb),
    .op_dat     (op_dat),
    .digit_full (digit_full),
    .op_ack     (op_ack),
    .digit_push (digit_push),
    .digit_data (enc_digit)
  );

  sync_fifo #(
    .DEPTH (bus_pkg::DIGIT_FIFO_DEPTH),
    .T     (booth_pkg::digit_t)
  ) digit_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (clear),
    .push  (digit_push),
    .wdata (enc_digit),
    .pop   (digit_pop),
    .rdata (head_digit),
    .full  (digit_full),
    .empty (digit_empty)
  );

  booth_accumulator i_booth_accumulator (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (clear),
    .digit_data  (head_digit),
    .digit_empty (digit_empty),
    .res_full    (res_full),
    .digit_pop   (digit_pop),
    .res_push    (res_push),
    .res_data    (acc_product)
  );

  sync_fifo #(
    .DEPTH (bus_pkg::RESULT_FIFO_DEPTH),
    .T     (booth_pkg::product_t)
  ) result_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (clear),
    .push  (res_push),
    .wdata (acc_product),
    .pop   (res_pop),
    .rdata (head_product),
    .full  (res_full),
    .empty (res_empty)
  );

  result_master i_result_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .res_data  (head_product),
    .res_empty (res_empty),
    .res_ack   (res_ack),
    .res_pop   (res_pop),
    .res_cyc   (res_cyc),
    .res_stb   (res_stb),
    .res_dat   (res_dat)
  );

endmodule

// ==== design/operand_encoder.sv ====
`timescale 1ns/100ps

module operand_encoder (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear,
  input  logic                        op_cyc,
  input  logic                        op_stb,
  input  logic [bus_pkg::DAT_W-1:0]   op_dat,
  input  logic                        digit_full,
  output logic                        op_ack,
  output logic                        digit_push,
  output booth_pkg::digit_t           digit_data
);

  typedef logic [$clog2(booth_pkg::NUM_DIGITS)-1:0] idx_t;

  logic                           busy;    // emitting digits
  idx_t                           idx;     // window being recoded
  logic                           accept;
  logic [booth_pkg::OP_W-1:0]     mplier;
  logic [booth_pkg::OP_W-1:0]     mcand;
  logic [booth_pkg::OP_W:0]       mplier_ext;  // multiplier with the appended zero
  logic [booth_pkg::RADIX_BITS:0] win;         // 5-bit overlapping window
  logic [booth_pkg::RADIX_BITS:0] recoded;

  assign accept = !busy && op_cyc && op_stb;  // strobe ignored while busy

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      op_ack <= 1'b0;
      idx    <= '0;
    end else if (clear) begin
      busy   <= 1'b0;  // abort, nothing acked this cycle
      op_ack <= 1'b0;
      idx    <= '0;
    end else begin
      op_ack <= accept;  // single-cycle pulse
      if (accept) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (digit_push) begin
        idx <= idx + 1'b1;
        if (idx == idx_t'(booth_pkg::NUM_DIGITS - 1)) begin
          busy <= 1'b0;  // fourth digit out
        end
      end
    end
  end

  // operand pair held for the whole emission
  always_ff @(posedge clk) begin
    if (accept) begin
      mplier <= op_dat[bus_pkg::DAT_W-1 -: booth_pkg::OP_W];
      mcand  <= op_dat[booth_pkg::OP_W-1:0];
    end
  end

  assign mplier_ext = {mplier, 1'b0};
  assign win = mplier_ext[idx*booth_pkg::RADIX_BITS +: booth_pkg::RADIX_BITS+1];

  // -8*b4 + 4*b3 + 2*b2 + b1 + b0, i.e. the signed top four bits plus b0
  assign recoded = {win[booth_pkg::RADIX_BITS], win[booth_pkg::RADIX_BITS:1]}
                 + {{booth_pkg::RADIX_BITS{1'b0}}, win[0]};

  assign digit_push = busy && !digit_full;  // wait on a full digit FIFO

  always_comb begin
    digit_data.digit = recoded;
    digit_data.mcand = mcand;
    digit_data.last  = (idx == idx_t'(booth_pkg::NUM_DIGITS - 1));
  end

endmodule

// ==== design/result_master.sv ====
`timescale 1ns/100ps

module result_master (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  booth_pkg::product_t res_data,
  input  logic                res_empty,
  input  logic                res_ack,
  output logic                res_pop,
  output logic                res_cyc,
  output logic                res_stb,
  output booth_pkg::product_t res_dat
);

  typedef enum logic {
    IDLE,
    BUS
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else if (clear) begin
      state <= IDLE;  // drop the transfer in flight
    end else begin
      case (state)
        IDLE:    if (!res_empty) state <= BUS;
        BUS:     if (res_ack) state <= IDLE;  // one idle cycle follows
        default: state <= IDLE;
      endcase
    end
  end

  // product held stable for the whole transfer
  always_ff @(posedge clk) begin
    if (state == IDLE && !res_empty) begin
      res_dat <= res_data;
    end
  end

  assign res_cyc = (state == BUS);
  assign res_stb = (state == BUS);
  assign res_pop = (state == BUS) && res_ack;  // head retired on ack

endmodule

// ==== design/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  input  logic push,
  input  T     wdata,
  input  logic pop,
  output T     rdata,
  output logic full,
  output logic empty
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  T     mem [DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;   // occupancy
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;  // drops every entry at once
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push && !flush) begin
      mem[wr_ptr] <= wdata;
    end
  end

  assign rdata = mem[rd_ptr];  // head, valid while not empty
  assign full  = (count == cnt_t'(DEPTH));
  assign empty = (count == '0);

endmodule

// ==== tb/mult_top_sva.sv ====
`timescale 1ns/100ps

module mult_top_sva (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          clear,
  input logic                          op_cyc,
  input logic                          op_stb,
  input logic [bus_pkg::DAT_W-1:0]     op_dat,
  input logic                          op_ack,
  input logic                          res_cyc,
  input logic                          res_stb,
  input logic [booth_pkg::PROD_W-1:0]  res_dat,
  input logic                          res_ack
);

  op_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    op_stb && !op_ack |=> op_stb && $stable(op_dat))  // master waits for ack
    else $error("operand strobe or data changed before op_ack");

  op_ack_a : assert property (@(posedge clk) disable iff (!rst_n)
    op_ack |-> op_cyc && op_stb)
    else $error("op_ack without an operand request");

  op_pulse_a : assert property (@(posedge clk) disable iff (!rst_n)
    op_ack |=> !op_ack)  // single-cycle ack
    else $error("op_ack held longer than one cycle");

  res_hold_a : assert property (@(posedge clk) disable iff (!rst_n || clear)
    res_stb && !res_ack |=> res_stb && $stable(res_dat))
    else $error("result strobe or data changed before res_ack");

  res_cyc_a : assert property (@(posedge clk) disable iff (!rst_n)
    res_stb |-> res_cyc)
    else $error("res_stb without res_cyc");

  reset_a : assert property (@(posedge clk)
    $rose(rst_n) |-> !op_ack && !res_cyc && !res_stb)
    else $error("bus outputs not idle after reset");

endmodule

bind mult_top mult_top_sva i_mult_top_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .clear   (clear),
  .op_cyc  (op_cyc),
  .op_stb  (op_stb),
  .op_dat  (op_dat),
  .op_ack  (op_ack),
  .res_cyc (res_cyc),
  .res_stb (res_stb),
  .res_dat (res_dat),
  .res_ack (res_ack)
);

// ==== tb/mult_top_tb.sv ====
`timescale 1ns/100ps

module mult_top_tb;

  localparam int NUM_DIRECTED = 14;
  localparam int ACK_TIMEOUT  = 200;  // cycles for a backed-up pipeline
  localparam int STB_TIMEOUT  = 200;

  logic                      clk;
  logic                      rst_n;
  logic                      clear;
  logic                      op_cyc;
  logic                      op_stb;
  logic [bus_pkg::DAT_W-1:0] op_dat;
  logic                      op_ack;
  logic                      res_cyc;
  logic                      res_stb;
  booth_pkg::product_t       res_dat;
  logic                      res_ack;

  logic [31:0] op_q  [$];  // operand words still to send
  logic [31:0] exp_q [$];  // products still due in order
  int          checks;
  int          errors;
  int          mark_checks;
  int          mark_errors;
  int          tests_run;

  // multiplier, multiplicand, expected product
  logic [63:0] directed_tab [NUM_DIRECTED] = '{
    {16'h0000, 16'h0000, 32'h0000_0000},
    {16'h0001, 16'h0001, 32'h0000_0001},
    {16'hFFFF, 16'h0001, 32'hFFFF_FFFF},
    {16'hFFFF, 16'hFFFF, 32'h0000_0001},
    {16'h7FFF, 16'h7FFF, 32'h3FFF_0001},
    {16'h8000, 16'h8000, 32'h4000_0000},
    {16'h8000, 16'h7FFF, 32'hC000_8000},
    {16'h7FFF, 16'h8000, 32'hC000_8000},
    {16'h0000, 16'h8000, 32'h0000_0000},
    {16'h8000, 16'h0001, 32'hFFFF_8000},
    {16'h04D2, 16'hFDC9, 32'hFFF5_52E2},  // 1234 * -567
    {16'hFED4, 16'hFED4, 32'h0001_5F90},  // -300 * -300
    {16'hFFF9, 16'h0009, 32'hFFFF_FFC1},  // -7 * 9
    {16'h1234, 16'h0010, 32'h0001_2340}
  };

  mult_top i_mult_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (clear),
    .op_cyc  (op_cyc),
    .op_stb  (op_stb),
    .op_dat  (op_dat),
    .op_ack  (op_ack),
    .res_cyc (res_cyc),
    .res_stb (res_stb),
    .res_dat (res_dat),
    .res_ack (res_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] signed_product(input logic [31:0] word);
    logic signed [31:0] mplier;
    logic signed [31:0] mcand;
    mplier = {{16{word[31]}}, word[31:16]};
    mcand  = {{16{word[15]}}, word[15:0]};
    return mplier * mcand;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic wait_op_ack();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!op_ack && waited < ACK_TIMEOUT);
    if (!op_ack) begin
      abort_run("timeout: the operand write was never acknowledged");
    end
  endtask

  task automatic wait_res_stb();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!res_stb && waited < STB_TIMEOUT);
    if (!res_stb) begin
      abort_run("timeout: an expected product never appeared on the result bus");
    end
  endtask

  task automatic send_op(input logic [31:0] word, input logic with_clear);
    op_cyc <= 1'b1;
    op_stb <= 1'b1;
    op_dat <= word;
    wait_op_ack();
    op_cyc <= 1'b0;
    op_stb <= 1'b0;
    clear  <= with_clear;  // abort right behind the ack
    @(posedge clk);
    clear  <= 1'b0;
  endtask

  task automatic drive_ops();
    while (op_q.size() > 0) begin
      send_op(op_q.pop_front(), 1'b0);
    end
  endtask

  task automatic collect_products(input int max_delay);
    logic [31:0] expected;
    int          delay;
    while (exp_q.size() > 0) begin
      wait_res_stb();
      expected = exp_q.pop_front();
      check_value("res_dat", res_dat, expected);
      delay = int'($urandom_range(max_delay, 0));
      repeat (delay) @(posedge clk);  // hold off the ack
      res_ack <= 1'b1;
      @(posedge clk);
      res_ack <= 1'b0;
    end
  endtask

  // no product may show up in the window
  task automatic expect_quiet(input int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      seen = seen | res_stb;
    end
    checks++;
    if (seen) begin
      errors++;
      $display("a product appeared on the result bus when none was due");
    end
  endtask

  task automatic run_stream(input int max_delay);
    fork
      drive_ops();
      collect_products(max_delay);
    join
    expect_quiet(30);  // catches duplicates
  endtask

  task automatic queue_random(input int count);
    logic [31:0] word;
    for (int i = 0; i < count; i++) begin
      word = $urandom();
      op_q.push_back(word);
      exp_q.push_back(signed_product(word));
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("%s: %0d checks, %0d errors", name, checks - mark_checks,
             errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  initial begin
    rst_n       = 1'b0;
    clear       = 1'b0;
    op_cyc      = 1'b0;
    op_stb      = 1'b0;
    op_dat      = '0;
    res_ack     = 1'b0;
    checks      = 0;
    errors      = 0;
    mark_checks = 0;
    mark_errors = 0;
    tests_run   = 0;
    void'($urandom(96189));

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("op_ack", 32'(op_ack), 32'h0);
    check_value("res_cyc", 32'(res_cyc), 32'h0);
    check_value("res_stb", 32'(res_stb), 32'h0);
    end_test("reset");

    for (int i = 0; i < NUM_DIRECTED; i++) begin
      op_q.push_back(directed_tab[i][63:32]);
      exp_q.push_back(directed_tab[i][31:0]);
    end
    run_stream(0);
    end_test("directed table");

    queue_random(200);
    run_stream(0);
    end_test("random streaming");

    queue_random(100);
    run_stream(10);  // ack held off up to 10 cycles
    end_test("back-pressure");

    send_op(32'h0123_4567, 1'b1);
    expect_quiet(50);
    op_q.push_back(32'h8000_7FFF);
    exp_q.push_back(signed_product(32'h8000_7FFF));
    run_stream(0);
    end_test("clear");

    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
